// File: Bender.yml
package:
  name: trace_monitor

sources:
  - common/trace_pkg.sv
  - common/exec_trace_if.sv
  - trace_mon/r3_shadow.sv
  - trace_mon/nop_decoder.sv
  - trace_mon/event_builder.sv
  - trace_mon/term_collect.sv
  - verilog/trace_monitor_top.sv
  - target: test
    files:
      - tests/trace_monitor_sva.sv
      - tests/tb_trace_monitor.sv

// File: common/exec_trace_if.sv
// Retirement trace of one core
// Valid strobe, retired pc and instruction, and the register
// write-back of that instruction
`timescale 1ns/1ps

interface exec_trace_if;

   // Retirement strobe
   logic                                   valid;
   logic [trace_pkg::DATA_WIDTH-1:0]       pc;
   logic [trace_pkg::DATA_WIDTH-1:0]       insn;

   // Register write-back, qualified by valid
   logic                                   wben;
   logic [trace_pkg::REG_INDEX_WIDTH-1:0]  wbreg;
   logic [trace_pkg::DATA_WIDTH-1:0]       wbdata;

   // Core side produces the trace
   modport core (
      output valid, pc, insn, wben, wbreg, wbdata
   );

   // Monitor side only observes
   modport monitor (
      input valid, pc, insn, wben, wbreg, wbdata
   );

endinterface

// File: common/trace_pkg.sv
// Trace monitor shared definitions
// Holds the data widths, the l.nop request encoding used by the
// simulator hooks and the event type emitted per core
package trace_pkg;

   // Width of pc, instruction and register data
   localparam int unsigned DATA_WIDTH = 32;

   // Register file index width, 32 GPRs
   localparam int unsigned REG_INDEX_WIDTH = 5;

   // Register carrying the request argument
   localparam logic [REG_INDEX_WIDTH-1:0] R3_INDEX = 5'd3;

   // l.nop major opcode in insn[31:24]
   localparam logic [7:0] NOP_OPCODE = 8'h15;

   // Request immediates in insn[15:0]
   localparam logic [15:0] NOP_EXIT   = 16'h0001;
   localparam logic [15:0] NOP_REPORT = 16'h0002;
   localparam logic [15:0] NOP_PUTC   = 16'h0004;

   // Simulator request kinds
   // EV_NONE means no request retired
   typedef enum logic [1:0] {
      EV_NONE   = 2'd0,
      EV_EXIT   = 2'd1,
      EV_REPORT = 2'd2,
      EV_PUTC   = 2'd3
   } trace_event_e;

   // One emitted event
   // Data is r3, or its low byte for putc
   typedef struct packed {
      trace_event_e            kind;
      logic [DATA_WIDTH-1:0]   data;
   } trace_event_t;

endpackage

// File: flist.f
common/trace_pkg.sv
common/exec_trace_if.sv
trace_mon/r3_shadow.sv
trace_mon/nop_decoder.sv
trace_mon/event_builder.sv
trace_mon/term_collect.sv
verilog/trace_monitor_top.sv
tests/trace_monitor_sva.sv
tests/tb_trace_monitor.sv

// File: tests/tb_trace_monitor.sv
// Testbench for the execution trace monitor
// Table of per-cycle trace steps with expected events, exit flags and done
`timescale 1ns/1ps

module tb_trace_monitor;

   localparam int unsigned NUM_CORES = 4;
   localparam int unsigned DW        = trace_pkg::DATA_WIDTH;
   localparam int unsigned RW        = trace_pkg::REG_INDEX_WIDTH;
   localparam int unsigned MAX_STEPS = 64;
   // Plain ALU op without the nop opcode
   localparam logic [DW-1:0] ALU_INSN = 32'he063_2000;

   typedef struct packed {
      logic [3:0]              test;
      logic                    rst;
      logic [1:0]              core;
      logic                    valid;
      logic [DW-1:0]           insn;
      logic                    wben;
      logic [RW-1:0]           wbreg;
      logic [DW-1:0]           wbdata;
      logic                    exp_valid;
      trace_pkg::trace_event_e exp_kind;
      logic [DW-1:0]           exp_data;
      logic [NUM_CORES-1:0]    exp_exited;
      logic                    exp_done;
   } step_t;

   logic                                 clk;
   logic                                 rst_n;
   logic [NUM_CORES-1:0]                 trace_valid;
   logic [NUM_CORES-1:0][DW-1:0]         trace_pc;
   logic [NUM_CORES-1:0][DW-1:0]         trace_insn;
   logic [NUM_CORES-1:0]                 trace_wben;
   logic [NUM_CORES-1:0][RW-1:0]         trace_wbreg;
   logic [NUM_CORES-1:0][DW-1:0]         trace_wbdata;
   logic [NUM_CORES-1:0]                 event_valid;
   trace_pkg::trace_event_e [NUM_CORES-1:0] event_kind;
   logic [NUM_CORES-1:0][DW-1:0]         event_data;
   logic [NUM_CORES-1:0]                 exited;
   logic                                 done;

   step_t                steps [MAX_STEPS];
   step_t                idle_step;
   string                test_names [6];
   int                   n_steps;
   int                   cycles;
   int                   cycle_limit = 1000;
   int                   err_test;
   int                   err_total;
   int                   tests_run;
   int                   tests_failed;
   logic [31:0]          rng;
   // Reference state while the table is built
   logic [DW-1:0]        r3_model [NUM_CORES];
   logic [NUM_CORES-1:0] exited_model;
   logic                 done_model;
   // Assertion failures of the bound checkers
   int unsigned          sva_fails [NUM_CORES+1];
   int unsigned          sva_total;

   trace_monitor_top #(
      .NUM_CORES (NUM_CORES)
   ) i_trace_monitor_top (
      .clk          (clk),
      .rst_n        (rst_n),
      .trace_valid  (trace_valid),
      .trace_pc     (trace_pc),
      .trace_insn   (trace_insn),
      .trace_wben   (trace_wben),
      .trace_wbreg  (trace_wbreg),
      .trace_wbdata (trace_wbdata),
      .event_valid  (event_valid),
      .event_kind   (event_kind),
      .event_data   (event_data),
      .exited       (exited),
      .done         (done)
   );

   // One checker per event builder plus the collector
   for (genvar g = 0; g < NUM_CORES; g++) begin : gen_sva_fails
      assign sva_fails[g] =
         i_trace_monitor_top.gen_core[g].u_event_builder.u_event_sva.fail_count;
   end
   assign sva_fails[NUM_CORES] = i_trace_monitor_top.u_term_collect.u_done_sva.fail_count;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Run limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout: the step table did not finish within %0d cycles", cycle_limit);
         $display("Verification failed");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [DW-1:0] nop_insn(input logic [15:0] imm);
      return {trace_pkg::NOP_OPCODE, 8'h00, imm};
   endfunction

   // Expected values follow the per-cycle rules of the monitor
   task automatic add_row(input int test, input int core, input logic valid,
                          input logic [DW-1:0] insn, input logic wben,
                          input logic [RW-1:0] wbreg, input logic [DW-1:0] wbdata,
                          input trace_pkg::trace_event_e kind);
      step_t s;
      s = '0;
      // Done follows the flags of the previous cycle
      done_model = done_model | (&exited_model);
      s.test = test[3:0];
      s.core = core[1:0];
      s.valid = valid;
      s.insn = insn;
      s.wben = wben;
      s.wbreg = wbreg;
      s.wbdata = wbdata;
      s.exp_valid = (kind != trace_pkg::EV_NONE);
      s.exp_kind = kind;
      if (kind == trace_pkg::EV_PUTC) begin
         s.exp_data = {{(DW-8){1'b0}}, r3_model[core][7:0]};
      end else begin
         s.exp_data = r3_model[core];
      end
      if (kind == trace_pkg::EV_EXIT) begin
         exited_model[core] = 1'b1;
      end
      // Qualified r3 write seen from the next row on
      if (valid && wben && wbreg == trace_pkg::R3_INDEX) begin
         r3_model[core] = wbdata;
      end
      s.exp_exited = exited_model;
      s.exp_done = done_model;
      steps[n_steps] = s;
      n_steps++;
   endtask

   task automatic add_reset(input int test);
      step_t s;
      s = '0;
      s.test = test[3:0];
      s.rst = 1'b1;
      exited_model = '0;
      done_model = 1'b0;
      foreach (r3_model[c]) begin
         r3_model[c] = '0;
      end
      steps[n_steps] = s;
      n_steps++;
   endtask

   // Only the row's core is active
   task automatic apply_step(input step_t s, input int idx);
      logic [NUM_CORES-1:0]         valid_v;
      logic [NUM_CORES-1:0]         wben_v;
      logic [NUM_CORES-1:0][DW-1:0] pc_v;
      logic [NUM_CORES-1:0][DW-1:0] insn_v;
      logic [NUM_CORES-1:0][DW-1:0] data_v;
      logic [NUM_CORES-1:0][RW-1:0] reg_v;
      valid_v = '0;
      wben_v = '0;
      pc_v = '0;
      insn_v = '0;
      data_v = '0;
      reg_v = '0;
      valid_v[s.core] = s.valid;
      wben_v[s.core] = s.wben;
      pc_v[s.core] = 32'(idx) << 2;
      insn_v[s.core] = s.insn;
      data_v[s.core] = s.wbdata;
      reg_v[s.core] = s.wbreg;
      rst_n <= !s.rst;
      trace_valid <= valid_v;
      trace_wben <= wben_v;
      trace_pc <= pc_v;
      trace_insn <= insn_v;
      trace_wbdata <= data_v;
      trace_wbreg <= reg_v;
   endtask

   task automatic check_step(input step_t s);
      logic [NUM_CORES-1:0] exp_ev;
      exp_ev = '0;
      exp_ev[s.core] = s.exp_valid;
      if (event_valid !== exp_ev) begin
         $display("CHECK FAILED at %0t: event_valid %b, expected %b", $time, event_valid, exp_ev);
         err_test++;
      end
      if (s.exp_valid && event_kind[s.core] !== s.exp_kind) begin
         $display("CHECK FAILED at %0t: core %0d kind %0d, expected %0d",
                  $time, s.core, event_kind[s.core], s.exp_kind);
         err_test++;
      end
      if (s.exp_valid && event_data[s.core] !== s.exp_data) begin
         $display("CHECK FAILED at %0t: core %0d data %h, expected %h",
                  $time, s.core, event_data[s.core], s.exp_data);
         err_test++;
      end
      if (exited !== s.exp_exited) begin
         $display("CHECK FAILED at %0t: exited %b, expected %b", $time, exited, s.exp_exited);
         err_test++;
      end
      if (done !== s.exp_done) begin
         $display("CHECK FAILED at %0t: done %b, expected %b", $time, done, s.exp_done);
         err_test++;
      end
   endtask

   task automatic finish_test(input int test);
      $display("Test %0d %s: %0d errors", test, test_names[test], err_test);
      tests_run++;
      if (err_test != 0) begin
         tests_failed++;
      end
      err_total += err_test;
      err_test = 0;
   endtask

   initial begin
      rst_n <= 1'b0;
      trace_valid <= '0;
      trace_pc <= '0;
      trace_insn <= '0;
      trace_wben <= '0;
      trace_wbreg <= '0;
      trace_wbdata <= '0;
      cycles = 0;
      idle_step = '0;
      rng = 32'h15be;
      n_steps = 0;
      exited_model = '0;
      done_model = 1'b0;
      foreach (r3_model[c]) begin
         r3_model[c] = '0;
      end
      test_names = '{"putc", "report_exit", "non_request", "shadow_qual", "termination", "reset"};
      // Putc on two cores
      rng = lcg_next(rng);
      add_row(0, 0, 1'b1, ALU_INSN, 1'b1, 5'd3, rng, trace_pkg::EV_NONE);
      add_row(0, 0, 1'b1, nop_insn(trace_pkg::NOP_PUTC), 1'b0, 5'd0, '0, trace_pkg::EV_PUTC);
      rng = lcg_next(rng);
      add_row(0, 3, 1'b1, ALU_INSN, 1'b1, 5'd3, rng, trace_pkg::EV_NONE);
      add_row(0, 3, 1'b1, nop_insn(trace_pkg::NOP_PUTC), 1'b0, 5'd0, '0, trace_pkg::EV_PUTC);
      // Write right before report, then exit, then report after exit
      rng = lcg_next(rng);
      add_row(1, 1, 1'b1, ALU_INSN, 1'b1, 5'd3, rng, trace_pkg::EV_NONE);
      add_row(1, 1, 1'b1, nop_insn(trace_pkg::NOP_REPORT), 1'b0, 5'd0, '0, trace_pkg::EV_REPORT);
      add_row(1, 1, 1'b1, nop_insn(trace_pkg::NOP_EXIT), 1'b0, 5'd0, '0, trace_pkg::EV_EXIT);
      add_row(1, 1, 1'b1, nop_insn(trace_pkg::NOP_REPORT), 1'b0, 5'd0, '0, trace_pkg::EV_REPORT);
      // Plain op, other immediates, invalid nop, wrong opcode
      add_row(2, 2, 1'b1, ALU_INSN, 1'b0, 5'd0, '0, trace_pkg::EV_NONE);
      add_row(2, 2, 1'b1, nop_insn(16'h0000), 1'b0, 5'd0, '0, trace_pkg::EV_NONE);
      add_row(2, 2, 1'b1, nop_insn(16'h0003), 1'b0, 5'd0, '0, trace_pkg::EV_NONE);
      add_row(2, 2, 1'b0, nop_insn(trace_pkg::NOP_EXIT), 1'b0, 5'd0, '0, trace_pkg::EV_NONE);
      add_row(2, 2, 1'b1, 32'h1400_0002, 1'b0, 5'd0, '0, trace_pkg::EV_NONE);
      // Only the first write lands in r3
      rng = lcg_next(rng);
      add_row(3, 2, 1'b1, ALU_INSN, 1'b1, 5'd3, rng, trace_pkg::EV_NONE);
      rng = lcg_next(rng);
      add_row(3, 2, 1'b1, ALU_INSN, 1'b1, 5'd4, rng, trace_pkg::EV_NONE);
      rng = lcg_next(rng);
      add_row(3, 2, 1'b1, ALU_INSN, 1'b0, 5'd3, rng, trace_pkg::EV_NONE);
      rng = lcg_next(rng);
      add_row(3, 2, 1'b0, ALU_INSN, 1'b1, 5'd3, rng, trace_pkg::EV_NONE);
      add_row(3, 2, 1'b1, nop_insn(trace_pkg::NOP_REPORT), 1'b0, 5'd0, '0, trace_pkg::EV_REPORT);
      // Remaining cores exit and done follows the last one
      add_row(4, 0, 1'b1, nop_insn(trace_pkg::NOP_EXIT), 1'b0, 5'd0, '0, trace_pkg::EV_EXIT);
      add_row(4, 0, 1'b0, '0, 1'b0, 5'd0, '0, trace_pkg::EV_NONE);
      add_row(4, 2, 1'b1, nop_insn(trace_pkg::NOP_EXIT), 1'b0, 5'd0, '0, trace_pkg::EV_EXIT);
      add_row(4, 0, 1'b0, '0, 1'b0, 5'd0, '0, trace_pkg::EV_NONE);
      add_row(4, 3, 1'b1, nop_insn(trace_pkg::NOP_EXIT), 1'b0, 5'd0, '0, trace_pkg::EV_EXIT);
      add_row(4, 0, 1'b0, '0, 1'b0, 5'd0, '0, trace_pkg::EV_NONE);
      add_row(4, 0, 1'b0, '0, 1'b0, 5'd0, '0, trace_pkg::EV_NONE);
      // Report after reset carries zero
      add_reset(5);
      add_row(5, 0, 1'b1, nop_insn(trace_pkg::NOP_REPORT), 1'b0, 5'd0, '0, trace_pkg::EV_REPORT);
      add_row(5, 0, 1'b0, '0, 1'b0, 5'd0, '0, trace_pkg::EV_NONE);
      cycle_limit = 2 * n_steps + 50;

      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      // Row i driven while row i-1 registers on this edge
      for (int i = 0; i <= n_steps; i++) begin
         @(posedge clk);
         if (i < n_steps) begin
            apply_step(steps[i], i);
         end else begin
            apply_step(idle_step, i);
         end
         @(negedge clk);
         if (i > 0) begin
            check_step(steps[i-1]);
            if (i == n_steps || steps[i].test != steps[i-1].test) begin
               finish_test(steps[i-1].test);
            end
         end
      end
      sva_total = 0;
      foreach (sva_fails[k]) begin
         sva_total += sva_fails[k];
      end
      $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
               tests_run, tests_failed, err_total, sva_total);
      if (err_total == 0 && sva_total == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: tests/trace_monitor_sva.sv
// Event and termination assertions
// Bound to each event builder and to the collector
// Strobe must follow a cause and sticky flags never fall until reset
`timescale 1ns/1ps

module trace_monitor_sva #(
   parameter int unsigned WIDTH = 1
) (
   input logic             clk,
   input logic             rst_n,
   input logic             strobe,
   input logic             strobe_cause,
   input logic [WIDTH-1:0] sticky
);

   // Failed assertions seen by this checker
   int unsigned fail_count = 0;

   // Event pulse or done needs its cause one cycle earlier
   a_strobe_cause : assert property (@(posedge clk) disable iff (!rst_n)
      strobe |-> $past(strobe_cause))
      else begin
         fail_count++;
         $error("strobe high without a cause in the previous cycle");
      end

   // Exit flags only clear through reset
   a_sticky_hold : assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |-> !(|($past(sticky) & ~sticky)))
      else begin
         fail_count++;
         $error("sticky flag fell without reset");
      end

endmodule

bind event_builder trace_monitor_sva #(.WIDTH(1)) u_event_sva (
   .clk          (clk),
   .rst_n        (rst_n),
   .strobe       (event_valid),
   .strobe_cause (kind != trace_pkg::EV_NONE),
   .sticky       (exited)
);

bind term_collect trace_monitor_sva #(.WIDTH(NUM_CORES)) u_done_sva (
   .clk          (clk),
   .rst_n        (rst_n),
   .strobe       (done),
   .strobe_cause (&exited),
   .sticky       (exited)
);

// File: trace_mon/event_builder.sv
// Event builder for one core
// Combines the decoded request with the shadow r3 into a registered
// event one cycle after retirement, and holds the sticky exit flag
`timescale 1ns/1ps

module event_builder (
   input  logic                             clk,
   input  logic                             rst_n,
   input  trace_pkg::trace_event_e          kind,
   input  logic [trace_pkg::DATA_WIDTH-1:0] r3,
   output logic                             event_valid,
   output trace_pkg::trace_event_t          event_out,
   output logic                             exited
);

   localparam int unsigned DW = trace_pkg::DATA_WIDTH;

   // Any request this cycle
   logic                    req;
   // Argument as it will be reported
   logic [DW-1:0]           req_data;
   // Registered event fields
   trace_pkg::trace_event_e kind_q;
   logic [DW-1:0]           data_q;

   assign req = (kind != trace_pkg::EV_NONE);

   // Putc carries one character, zero-extended
   always_comb begin
      if (kind == trace_pkg::EV_PUTC) begin
         req_data = {{(DW-8){1'b0}}, r3[7:0]};
      end else begin
         req_data = r3;
      end
   end

   // Strobe and kind
   // Exit flag sets with the exit event and holds until reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         event_valid <= 1'b0;
         kind_q      <= trace_pkg::EV_NONE;
         exited      <= 1'b0;
      end else begin
         event_valid <= req;
         kind_q      <= kind;
         if (kind == trace_pkg::EV_EXIT) begin
            exited <= 1'b1;
         end
      end
   end

   // Payload only loads on a request
   always_ff @(posedge clk) begin
      if (req) begin
         data_q <= req_data;
      end
   end

   assign event_out = '{kind: kind_q, data: data_q};

endmodule

// File: trace_mon/nop_decoder.sv
// Simulator request decoder
// Classifies the retiring instruction of one core as an l.nop
// exit, report or putc request, or as no request at all
`timescale 1ns/1ps

module nop_decoder (
   exec_trace_if.monitor            trace,
   output trace_pkg::trace_event_e  kind
);

   // Major opcode match
   logic        is_nop;
   // Request selector
   logic [15:0] nop_imm;

   assign is_nop  = (trace.insn[31:24] == trace_pkg::NOP_OPCODE);
   assign nop_imm = trace.insn[15:0];

   // Only a retiring instruction counts
   // Other l.nop immediates are plain nops
   always_comb begin
      kind = trace_pkg::EV_NONE;
      if (trace.valid && is_nop) begin
         case (nop_imm)
            trace_pkg::NOP_EXIT:   kind = trace_pkg::EV_EXIT;
            trace_pkg::NOP_REPORT: kind = trace_pkg::EV_REPORT;
            trace_pkg::NOP_PUTC:   kind = trace_pkg::EV_PUTC;
            default:               kind = trace_pkg::EV_NONE;
         endcase
      end
   end

endmodule

// File: trace_mon/r3_shadow.sv
// Shadow copy of register r3
// Follows the write-back stream of one core and keeps the last
// value written to r3, used as the argument of simulator requests
`timescale 1ns/1ps

module r3_shadow (
   input  logic                             clk,
   input  logic                             rst_n,
   exec_trace_if.monitor                    trace,
   output logic [trace_pkg::DATA_WIDTH-1:0] r3
);

   // Write that actually lands in r3
   logic r3_write;

   // Needs both valid and wben
   // Writes to other registers are ignored
   assign r3_write = trace.valid
                     && trace.wben
                     && (trace.wbreg == trace_pkg::R3_INDEX);

   // New value visible from the next cycle on
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r3 <= '0;
      end else if (r3_write) begin
         r3 <= trace.wbdata;
      end
   end

endmodule

// File: trace_mon/term_collect.sv
// Termination collector
// Watches the sticky exit flags of all cores and raises one
// system-wide done level once every core has exited
`timescale 1ns/1ps

module term_collect #(
   parameter int unsigned NUM_CORES = 4
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [NUM_CORES-1:0] exited,
   output logic                 done
);

   // Every core has left
   logic all_exited;

   // Flags are sticky upstream
   // so a plain AND is stable once true
   assign all_exited = &exited;

   // One cycle after the last flag sets
   // Stays high until reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         done <= 1'b0;
      end else if (all_exited) begin
         done <= 1'b1;
      end
   end

endmodule

// File: verilog/trace_monitor_top.sv
// Execution trace monitor
// One monitor slice per core decodes simulator requests from the
// retirement trace and reports them with the shadow r3 on its own
// event port; a collector signals when all cores have exited
`timescale 1ns/1ps

module trace_monitor_top #(
   parameter int unsigned NUM_CORES = 4
) (
   input  logic                                                     clk,
   input  logic                                                     rst_n,
   // Flat retirement traces, indexed by core
   input  logic [NUM_CORES-1:0]                                     trace_valid,
   input  logic [NUM_CORES-1:0][trace_pkg::DATA_WIDTH-1:0]          trace_pc,
   input  logic [NUM_CORES-1:0][trace_pkg::DATA_WIDTH-1:0]          trace_insn,
   input  logic [NUM_CORES-1:0]                                     trace_wben,
   input  logic [NUM_CORES-1:0][trace_pkg::REG_INDEX_WIDTH-1:0]     trace_wbreg,
   input  logic [NUM_CORES-1:0][trace_pkg::DATA_WIDTH-1:0]          trace_wbdata,
   // Per-core events
   output logic [NUM_CORES-1:0]                                     event_valid,
   output trace_pkg::trace_event_e [NUM_CORES-1:0]                  event_kind,
   output logic [NUM_CORES-1:0][trace_pkg::DATA_WIDTH-1:0]          event_data,
   output logic [NUM_CORES-1:0]                                     exited,
   // All cores done
   output logic                                                     done
);

   for (genvar c = 0; c < NUM_CORES; c++) begin : gen_core
      // This core's trace bundle
      exec_trace_if trace_bus ();

      logic [trace_pkg::DATA_WIDTH-1:0] r3;
      trace_pkg::trace_event_e          kind;
      trace_pkg::trace_event_t          ev;

      assign trace_bus.valid  = trace_valid[c];
      assign trace_bus.pc     = trace_pc[c];
      assign trace_bus.insn   = trace_insn[c];
      assign trace_bus.wben   = trace_wben[c];
      assign trace_bus.wbreg  = trace_wbreg[c];
      assign trace_bus.wbdata = trace_wbdata[c];

      // Shadow and decoder side by side
      r3_shadow u_r3_shadow (
         .clk   (clk),
         .rst_n (rst_n),
         .trace (trace_bus),
         .r3    (r3)
      );

      nop_decoder u_nop_decoder (
         .trace (trace_bus),
         .kind  (kind)
      );

      event_builder u_event_builder (
         .clk         (clk),
         .rst_n       (rst_n),
         .kind        (kind),
         .r3          (r3),
         .event_valid (event_valid[c]),
         .event_out   (ev),
         .exited      (exited[c])
      );

      // Split event onto flat ports
      assign event_kind[c] = ev.kind;
      assign event_data[c] = ev.data;
   end

   term_collect #(
      .NUM_CORES (NUM_CORES)
   ) u_term_collect (
      .clk    (clk),
      .rst_n  (rst_n),
      .exited (exited),
      .done   (done)
   );

endmodule
